// File: Makefile
VERILATOR ?= verilator
TOP ?= multiCycleCpuTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= all.f
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+source
source/mipsPkg.sv
source/controlIf.sv
source/alu.sv
source/registerFile.sv
source/unifiedMemory.sv
source/mainControl.sv
source/datapath.sv
source/multiCycleCpu.sv
testbench/multiCycleCpu_checker.sv
testbench/multiCycleCpuTb.sv

// File: source/alu.sv
module alu (
    input mipsPkg::aluClass_t aluClass,
    input mipsPkg::funct_t funct,
    input mipsPkg::word_t a,
    input mipsPkg::word_t b,
    output mipsPkg::word_t result,
    output logic zero
);
    mipsPkg::aluOp_t aluOp;

    // class from controller, funct only matters for r-type
    always_comb begin
        case (aluClass)
            mipsPkg::ALU_SUB: aluOp = mipsPkg::AOP_SUB;
            mipsPkg::ALU_LUI: aluOp = mipsPkg::AOP_LUI;
            mipsPkg::ALU_FUNCT: begin
                case (funct)
                    mipsPkg::FN_SUB: aluOp = mipsPkg::AOP_SUB;
                    mipsPkg::FN_AND: aluOp = mipsPkg::AOP_AND;
                    mipsPkg::FN_OR: aluOp = mipsPkg::AOP_OR;
                    mipsPkg::FN_SLT: aluOp = mipsPkg::AOP_SLT;
                    default: aluOp = mipsPkg::AOP_ADD;
                endcase
            end
            default: aluOp = mipsPkg::AOP_ADD;
        endcase
    end

    always_comb begin
        case (aluOp)
            mipsPkg::AOP_SUB: result = a - b;
            mipsPkg::AOP_AND: result = a & b;
            mipsPkg::AOP_OR: result = a | b;
            mipsPkg::AOP_SLT: result = mipsPkg::word_t'($signed(a) < $signed(b));
            // upper half from the low half of b
            mipsPkg::AOP_LUI: result = {b[15:0], 16'h0000};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);
endmodule

// File: source/controlIf.sv
interface controlIf;
    // bit 0 branches on zero, bit 1 on nonzero
    logic [1:0] pcWriteCond;
    logic pcWrite;
    logic iorD;
    logic memWrite;
    logic irWrite;
    logic memToReg;
    logic [1:0] pcSource;
    mipsPkg::aluClass_t aluClass;
    logic aluSrcA;
    logic [1:0] aluSrcB;
    logic regWrite;
    logic regDst;
    logic link;

    modport ctrl (
        output pcWriteCond, pcWrite, iorD, memWrite, irWrite, memToReg,
        output pcSource, aluClass, aluSrcA, aluSrcB, regWrite, regDst, link
    );

    modport dp (
        input pcWriteCond, pcWrite, iorD, memWrite, irWrite, memToReg,
        input pcSource, aluClass, aluSrcA, aluSrcB, regWrite, regDst, link
    );
endinterface

// File: source/datapath.sv
`include "mips_cfg.svh"

module datapath (
    input logic clk,
    input logic rst,
    controlIf.dp dp,
    output mipsPkg::word_t memAddress,
    output mipsPkg::word_t memWriteData,
    input mipsPkg::word_t memReadData,
    output mipsPkg::opcode_t opcode,
    output mipsPkg::funct_t funct,
    output mipsPkg::word_t instruction,
    output mipsPkg::word_t pcOut,
    input logic [$clog2(`REG_COUNT)-1:0] debugRegister,
    output mipsPkg::word_t debugData
);
    mipsPkg::word_t pc, ir, mdr, regA, regB, aluOut;
    mipsPkg::word_t readData1, readData2;
    mipsPkg::word_t aluA, aluB, aluResult, nextPc;
    mipsPkg::word_t signExtImm, shiftedImm, jumpAddress, writeData;
    logic [$clog2(`REG_COUNT)-1:0] writeRegister;
    logic aluZero;
    logic pcEnable;

    assign pcEnable = dp.pcWrite || (dp.pcWriteCond[0] && aluZero)
        || (dp.pcWriteCond[1] && !aluZero);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (pcEnable) begin
                pc <= nextPc;
            end
            if (dp.irWrite) begin
                ir <= memReadData;
            end
        end
    end

    // latched every cycle, ir holds them stable per instruction
    always_ff @(posedge clk) begin
        mdr <= memReadData;
        regA <= readData1;
        regB <= readData2;
        aluOut <= aluResult;
    end

    assign signExtImm = {{(`DATA_WIDTH-16){ir[15]}}, ir[15:0]};
    assign shiftedImm = signExtImm << 2;
    assign jumpAddress = {pc[31:28], ir[25:0], 2'b00};

    assign aluA = dp.aluSrcA ? regA : pc;

    always_comb begin
        case (dp.aluSrcB)
            2'd0: aluB = regB;
            2'd1: aluB = mipsPkg::word_t'(4);
            2'd2: aluB = signExtImm;
            default: aluB = shiftedImm;
        endcase
    end

    always_comb begin
        case (dp.pcSource)
            2'd1: nextPc = aluOut;
            2'd2: nextPc = jumpAddress;
            default: nextPc = aluResult;
        endcase
    end

    // r31 and the return pc for jal
    assign writeRegister = dp.link ? 5'd31 : (dp.regDst ? ir[15:11] : ir[20:16]);
    assign writeData = dp.link ? pc : (dp.memToReg ? mdr : aluOut);

    registerFile regFile (
        .clk(clk),
        .rst(rst),
        .readRegister1(ir[25:21]),
        .readRegister2(ir[20:16]),
        .writeRegister(writeRegister),
        .writeData(writeData),
        .writeEnable(dp.regWrite),
        .readData1(readData1),
        .readData2(readData2),
        .debugRegister(debugRegister),
        .debugData(debugData)
    );

    alu mainAlu (
        .aluClass(dp.aluClass),
        .funct(funct),
        .a(aluA),
        .b(aluB),
        .result(aluResult),
        .zero(aluZero)
    );

    assign memAddress = dp.iorD ? aluOut : pc;
    assign memWriteData = regB;
    assign opcode = mipsPkg::opcode_t'(ir[31:26]);
    assign funct = mipsPkg::funct_t'(ir[5:0]);
    assign instruction = ir;
    assign pcOut = pc;
endmodule

// File: source/mainControl.sv
module mainControl (
    input logic clk,
    input logic rst,
    input mipsPkg::opcode_t opcode,
    input mipsPkg::funct_t funct,
    controlIf.ctrl ctrl
);
    mipsPkg::ctrlState_t state;
    mipsPkg::ctrlState_t nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mipsPkg::S_FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = mipsPkg::S_FETCH;
        case (state)
            mipsPkg::S_FETCH: nextState = mipsPkg::S_DECODE;
            mipsPkg::S_DECODE: begin
                case (opcode)
                    mipsPkg::OP_LW, mipsPkg::OP_SW: nextState = mipsPkg::S_MEM_ADDR;
                    mipsPkg::OP_ADDI, mipsPkg::OP_LUI: nextState = mipsPkg::S_IMM_EXEC;
                    mipsPkg::OP_BEQ, mipsPkg::OP_BNE: nextState = mipsPkg::S_BRANCH;
                    mipsPkg::OP_J, mipsPkg::OP_JAL: nextState = mipsPkg::S_JUMP;
                    mipsPkg::OP_RTYPE: begin
                        // unsupported funct codes fall back to fetch like a nop
                        case (funct)
                            mipsPkg::FN_ADD, mipsPkg::FN_SUB, mipsPkg::FN_AND,
                            mipsPkg::FN_OR, mipsPkg::FN_SLT: nextState = mipsPkg::S_EXEC;
                            default: nextState = mipsPkg::S_FETCH;
                        endcase
                    end
                    default: nextState = mipsPkg::S_FETCH;
                endcase
            end
            mipsPkg::S_MEM_ADDR: begin
                if (opcode == mipsPkg::OP_LW) begin
                    nextState = mipsPkg::S_MEM_READ;
                end else begin
                    nextState = mipsPkg::S_MEM_WRITE;
                end
            end
            mipsPkg::S_MEM_READ: nextState = mipsPkg::S_LOAD_WB;
            mipsPkg::S_EXEC: nextState = mipsPkg::S_ALU_WB;
            mipsPkg::S_IMM_EXEC: nextState = mipsPkg::S_IMM_WB;
            default: nextState = mipsPkg::S_FETCH;
        endcase
    end

    always_comb begin
        ctrl.pcWrite = 1'b0;
        ctrl.pcWriteCond = 2'b00;
        ctrl.iorD = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.irWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.pcSource = 2'd0;
        ctrl.aluClass = mipsPkg::ALU_ADD;
        ctrl.aluSrcA = 1'b0;
        ctrl.aluSrcB = 2'd0;
        ctrl.regWrite = 1'b0;
        ctrl.regDst = 1'b0;
        ctrl.link = 1'b0;
        case (state)
            mipsPkg::S_FETCH: begin
                // pc + 4, held off until reset is released
                ctrl.irWrite = !rst;
                ctrl.pcWrite = !rst;
                ctrl.aluSrcB = 2'd1;
            end
            mipsPkg::S_DECODE: begin
                // branch target into alu-out
                ctrl.aluSrcB = 2'd3;
            end
            mipsPkg::S_MEM_ADDR, mipsPkg::S_MEM_READ: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'd2;
                ctrl.iorD = (state == mipsPkg::S_MEM_READ);
            end
            mipsPkg::S_MEM_WRITE: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'd2;
                ctrl.iorD = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            mipsPkg::S_LOAD_WB: begin
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::S_EXEC: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluClass = mipsPkg::ALU_FUNCT;
            end
            mipsPkg::S_ALU_WB: begin
                ctrl.regDst = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::S_IMM_EXEC: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'd2;
                if (opcode == mipsPkg::OP_LUI) begin
                    ctrl.aluClass = mipsPkg::ALU_LUI;
                end
            end
            mipsPkg::S_IMM_WB: ctrl.regWrite = 1'b1;
            mipsPkg::S_BRANCH: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluClass = mipsPkg::ALU_SUB;
                ctrl.pcSource = 2'd1;
                ctrl.pcWriteCond = (opcode == mipsPkg::OP_BNE) ? 2'b10 : 2'b01;
            end
            mipsPkg::S_JUMP: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSource = 2'd2;
                // jal saves the already incremented pc in r31
                ctrl.regWrite = (opcode == mipsPkg::OP_JAL);
                ctrl.link = (opcode == mipsPkg::OP_JAL);
            end
            default: ;
        endcase
    end
endmodule

// File: source/mipsPkg.sv
`include "mips_cfg.svh"

package mipsPkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_t;

    typedef enum logic [3:0] {
        S_FETCH,
        S_DECODE,
        S_MEM_ADDR,
        S_MEM_READ,
        S_LOAD_WB,
        S_MEM_WRITE,
        S_EXEC,
        S_ALU_WB,
        S_IMM_EXEC,
        S_IMM_WB,
        S_BRANCH,
        S_JUMP
    } ctrlState_t;

    // what the controller asks for
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_FUNCT,
        ALU_LUI
    } aluClass_t;

    typedef enum logic [2:0] {
        AOP_ADD,
        AOP_SUB,
        AOP_AND,
        AOP_OR,
        AOP_SLT,
        AOP_LUI
    } aluOp_t;

endpackage

// File: source/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// unified memory depth in 32-bit words
`define MEM_WORDS 256

// datapath width
`define DATA_WIDTH 32

// architectural registers
`define REG_COUNT 32

`endif

// File: source/multiCycleCpu.sv
`include "mips_cfg.svh"

module multiCycleCpu (
    input logic clk,
    input logic rst,
    input logic loadEnable,
    input logic [$clog2(`MEM_WORDS)-1:0] loadAddress,
    input mipsPkg::word_t loadData,
    input logic [$clog2(`REG_COUNT)-1:0] debugRegister,
    output mipsPkg::word_t debugData,
    output mipsPkg::word_t instruction,
    output mipsPkg::word_t pcOut
);
    mipsPkg::opcode_t opcode;
    mipsPkg::funct_t funct;
    mipsPkg::word_t memAddress;
    mipsPkg::word_t memWriteData;
    mipsPkg::word_t memReadData;

    controlIf ctrlBus ();

    mainControl control (
        .clk(clk),
        .rst(rst),
        .opcode(opcode),
        .funct(funct),
        .ctrl(ctrlBus.ctrl)
    );

    datapath path (
        .clk(clk),
        .rst(rst),
        .dp(ctrlBus.dp),
        .memAddress(memAddress),
        .memWriteData(memWriteData),
        .memReadData(memReadData),
        .opcode(opcode),
        .funct(funct),
        .instruction(instruction),
        .pcOut(pcOut),
        .debugRegister(debugRegister),
        .debugData(debugData)
    );

    // loading only takes effect while the core is held in reset
    unifiedMemory memory (
        .clk(clk),
        .address(memAddress),
        .writeEnable(ctrlBus.memWrite),
        .writeData(memWriteData),
        .readData(memReadData),
        .loadEnable(loadEnable && rst),
        .loadAddress(loadAddress),
        .loadData(loadData)
    );
endmodule

// File: source/registerFile.sv
`include "mips_cfg.svh"

module registerFile (
    input logic clk,
    input logic rst,
    input logic [$clog2(`REG_COUNT)-1:0] readRegister1,
    input logic [$clog2(`REG_COUNT)-1:0] readRegister2,
    input logic [$clog2(`REG_COUNT)-1:0] writeRegister,
    input mipsPkg::word_t writeData,
    input logic writeEnable,
    output mipsPkg::word_t readData1,
    output mipsPkg::word_t readData2,
    input logic [$clog2(`REG_COUNT)-1:0] debugRegister,
    output mipsPkg::word_t debugData
);
    mipsPkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeRegister != '0) begin
            regs[writeRegister] <= writeData;
        end
    end

    // r0 hardwired to zero
    assign readData1 = (readRegister1 == '0) ? '0 : regs[readRegister1];
    assign readData2 = (readRegister2 == '0) ? '0 : regs[readRegister2];
    assign debugData = (debugRegister == '0) ? '0 : regs[debugRegister];
endmodule

// File: source/unifiedMemory.sv
`include "mips_cfg.svh"

module unifiedMemory (
    input logic clk,
    input mipsPkg::word_t address,
    input logic writeEnable,
    input mipsPkg::word_t writeData,
    output mipsPkg::word_t readData,
    input logic loadEnable,
    input logic [$clog2(`MEM_WORDS)-1:0] loadAddress,
    input mipsPkg::word_t loadData
);
    localparam int indexBits = $clog2(`MEM_WORDS);

    mipsPkg::word_t mem [`MEM_WORDS];
    logic [indexBits-1:0] wordIndex;

    // byte address to word index
    assign wordIndex = address[indexBits+1:2];

    assign readData = mem[wordIndex];

    always_ff @(posedge clk) begin
        // program load wins over a core store
        if (loadEnable) begin
            mem[loadAddress] <= loadData;
        end else if (writeEnable) begin
            mem[wordIndex] <= writeData;
        end
    end
endmodule

// File: testbench/multiCycleCpuTb.sv
`include "mips_cfg.svh"

module multiCycleCpuTb;
    localparam int clockPeriod = 20;
    localparam int progLength = 40;
    localparam int programCount = 3;
    localparam int maxCpi = 5;
    localparam int addrBits = $clog2(`MEM_WORDS);
    localparam int regBits = $clog2(`REG_COUNT);
    localparam int programCycles = `MEM_WORDS + 2 * `REG_COUNT + (progLength + 1) * maxCpi;
    localparam int watchdogCycles = programCount * (programCycles + 64);

    logic clk;
    logic rst;
    logic loadEnable;
    logic [addrBits-1:0] loadAddress;
    mipsPkg::word_t loadData;
    logic [regBits-1:0] debugRegister;
    mipsPkg::word_t debugData;
    mipsPkg::word_t instruction;
    mipsPkg::word_t pcOut;

    mipsPkg::word_t modelMem [`MEM_WORDS];
    mipsPkg::word_t modelRegs [`REG_COUNT];
    mipsPkg::word_t expInstr [$];
    mipsPkg::word_t expPc [$];
    int expCycles [$];
    int fetchErrors;
    int registerErrors;
    int assertErrors;

    multiCycleCpu UUT (
        .clk(clk),
        .rst(rst),
        .loadEnable(loadEnable),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .debugRegister(debugRegister),
        .debugData(debugData),
        .instruction(instruction),
        .pcOut(pcOut)
    );

    always #(clockPeriod / 2) clk = ~clk;

    function automatic mipsPkg::word_t encodeR(int rs, int rt, int rd, mipsPkg::funct_t fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mipsPkg::word_t encodeI(mipsPkg::opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic mipsPkg::word_t encodeJ(mipsPkg::opcode_t op, int target);
        return {op, 26'(target)};
    endfunction

    task automatic compareFetch(mipsPkg::word_t expectedInstruction, mipsPkg::word_t expectedPc);
        if (instruction !== expectedInstruction || pcOut !== expectedPc) begin
            fetchErrors++;
            $display("ERR %0t: fetched %h with pc %h, expected %h with pc %h",
                $time, instruction, pcOut, expectedInstruction, expectedPc);
        end
    endtask

    task automatic compareRegister(int index, mipsPkg::word_t value);
        if (debugData !== value) begin
            registerErrors++;
            $display("ERR %0t: register %0d reads %h, expected %h",
                $time, index, debugData, value);
        end
    endtask

    // one debug read per cycle, sampled in the low phase
    task automatic checkRegisters(logic afterReset);
        for (int i = 0; i < `REG_COUNT; i++) begin
            @(negedge clk);
            debugRegister = regBits'(i);
            #(clockPeriod / 4);
            compareRegister(i, afterReset ? '0 : modelRegs[i]);
        end
    endtask

    task automatic buildImage();
        int kind;
        int rs;
        int rt;
        int rd;
        int target;
        int offset;
        // program words overwrite the low end of a random fill
        for (int i = 0; i < `MEM_WORDS; i++) begin
            modelMem[i] = $urandom();
        end
        for (int i = 0; i < progLength - 1; i++) begin
            kind = $urandom_range(13);
            rs = $urandom_range(31);
            rt = $urandom_range(31);
            rd = $urandom_range(31);
            // forward targets only, so every program reaches its end
            target = $urandom_range(progLength - 1, i + 1);
            offset = 32'h200 + 4 * $urandom_range(15);
            if ((kind == 9 || kind == 10) && $urandom_range(1) == 1) begin
                rt = rs;
            end
            case (kind)
                0: modelMem[i] = encodeR(rs, rt, rd, mipsPkg::FN_ADD);
                1: modelMem[i] = encodeR(rs, rt, rd, mipsPkg::FN_SUB);
                2: modelMem[i] = encodeR(rs, rt, rd, mipsPkg::FN_AND);
                3: modelMem[i] = encodeR(rs, rt, rd, mipsPkg::FN_OR);
                4: modelMem[i] = encodeR(rs, rt, rd, mipsPkg::FN_SLT);
                5: modelMem[i] = encodeI(mipsPkg::OP_ADDI, rs, rt, $urandom_range(16'hFFFF));
                6: modelMem[i] = encodeI(mipsPkg::OP_LUI, 0, rt, $urandom_range(16'hFFFF));
                7: modelMem[i] = encodeI(mipsPkg::OP_LW, 0, rt, offset);
                8: modelMem[i] = encodeI(mipsPkg::OP_SW, 0, rt, offset);
                9: modelMem[i] = encodeI(mipsPkg::OP_BEQ, rs, rt, target - i - 1);
                10: modelMem[i] = encodeI(mipsPkg::OP_BNE, rs, rt, target - i - 1);
                11: modelMem[i] = encodeJ(mipsPkg::OP_J, target);
                12: modelMem[i] = encodeJ(mipsPkg::OP_JAL, target);
                // opcode 0x3f is not decoded
                default: modelMem[i] = 32'hFC00_0000;
            endcase
        end
        modelMem[progLength-1] = encodeJ(mipsPkg::OP_J, progLength - 1);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < `MEM_WORDS; i++) begin
            @(negedge clk);
            rst = 1'b1;
            loadEnable = 1'b1;
            loadAddress = addrBits'(i);
            loadData = modelMem[i];
        end
        @(negedge clk);
        loadEnable = 1'b0;
        compareFetch('0, '0);
        // register sweep while still in reset
        checkRegisters(1'b1);
    endtask

    task automatic runModel();
        mipsPkg::word_t pc;
        mipsPkg::word_t ir;
        mipsPkg::word_t nextPc;
        mipsPkg::word_t imm;
        mipsPkg::word_t addr;
        int idx;
        int rs;
        int rt;
        int rd;
        int cycles;
        int endFetches;
        pc = '0;
        endFetches = 0;
        expInstr.delete();
        expPc.delete();
        expCycles.delete();
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        // stop once the closing self jump has been fetched twice
        while (endFetches < 2) begin
            idx = int'(pc[addrBits+1:2]);
            ir = modelMem[idx];
            rs = int'(ir[25:21]);
            rt = int'(ir[20:16]);
            rd = int'(ir[15:11]);
            imm = {{16{ir[15]}}, ir[15:0]};
            nextPc = pc + 4;
            cycles = 4;
            case (ir[31:26])
                mipsPkg::OP_RTYPE: begin
                    case (ir[5:0])
                        mipsPkg::FN_ADD: modelRegs[rd] = modelRegs[rs] + modelRegs[rt];
                        mipsPkg::FN_SUB: modelRegs[rd] = modelRegs[rs] - modelRegs[rt];
                        mipsPkg::FN_AND: modelRegs[rd] = modelRegs[rs] & modelRegs[rt];
                        mipsPkg::FN_OR: modelRegs[rd] = modelRegs[rs] | modelRegs[rt];
                        mipsPkg::FN_SLT: begin
                            modelRegs[rd] = ($signed(modelRegs[rs]) < $signed(modelRegs[rt]))
                                ? 32'd1 : 32'd0;
                        end
                        default: cycles = 2;
                    endcase
                end
                mipsPkg::OP_ADDI: modelRegs[rt] = modelRegs[rs] + imm;
                mipsPkg::OP_LUI: modelRegs[rt] = {ir[15:0], 16'h0000};
                mipsPkg::OP_LW: begin
                    addr = modelRegs[rs] + imm;
                    modelRegs[rt] = modelMem[addr[addrBits+1:2]];
                    cycles = 5;
                end
                mipsPkg::OP_SW: begin
                    addr = modelRegs[rs] + imm;
                    modelMem[addr[addrBits+1:2]] = modelRegs[rt];
                end
                mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                    cycles = 3;
                    if ((modelRegs[rs] == modelRegs[rt]) == (ir[31:26] == mipsPkg::OP_BEQ)) begin
                        nextPc = pc + 4 + (imm << 2);
                    end
                end
                mipsPkg::OP_J, mipsPkg::OP_JAL: begin
                    cycles = 3;
                    if (ir[31:26] == mipsPkg::OP_JAL) begin
                        modelRegs[31] = pc + 4;
                    end
                    nextPc = {nextPc[31:28], ir[25:0], 2'b00};
                end
                default: cycles = 2;
            endcase
            modelRegs[0] = '0;
            expInstr.push_back(ir);
            expPc.push_back(pc + 4);
            expCycles.push_back(cycles);
            if (idx == progLength - 1) begin
                endFetches++;
            end
            pc = nextPc;
        end
    endtask

    task automatic runProgram();
        @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < expInstr.size(); k++) begin
            @(negedge clk);
            compareFetch(expInstr[k], expPc[k]);
            repeat (expCycles[k] - 1) @(negedge clk);
        end
    endtask

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("watchdog expired, the simulation hung before all programs finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        loadEnable = 1'b0;
        loadAddress = '0;
        loadData = '0;
        debugRegister = '0;
        fetchErrors = 0;
        registerErrors = 0;
        void'($urandom(36177));
        for (int p = 0; p < programCount; p++) begin
            buildImage();
            loadProgram();
            runModel();
            runProgram();
            checkRegisters(1'b0);
        end
        assertErrors = UUT.stateChecks.failureCount;
        $display("errors: fetch %0d, register %0d, assertion %0d",
            fetchErrors, registerErrors, assertErrors);
        if (fetchErrors + registerErrors + assertErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// File: testbench/multiCycleCpu_checker.sv
module multiCycleCpu_checker (
    input logic clk,
    input logic rst,
    input mipsPkg::ctrlState_t state,
    input logic irWrite,
    input logic memWrite,
    input logic regWrite,
    input mipsPkg::word_t pcOut
);
    int failureCount = 0;

    irWriteInFetch: assert property (@(posedge clk) disable iff (rst)
        irWrite |-> state == mipsPkg::S_FETCH)
    else begin
        $error("instruction register written outside the fetch state");
        failureCount++;
    end

    storeOrWriteback: assert property (@(posedge clk) disable iff (rst)
        !(memWrite && regWrite))
    else begin
        $error("memory write and register write asserted together");
        failureCount++;
    end

    // enum has twelve states, the top four encodings are unused
    legalState: assert property (@(posedge clk) disable iff (rst)
        state <= mipsPkg::S_JUMP)
    else begin
        $error("control FSM reached an illegal state encoding");
        failureCount++;
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst)
        pcOut[1:0] == 2'b00)
    else begin
        $error("program counter is not word aligned");
        failureCount++;
    end
endmodule

// pcOut lives at the top, so the checks sit there and reach into the FSM
bind multiCycleCpu multiCycleCpu_checker stateChecks (
    .clk(clk),
    .rst(rst),
    .state(control.state),
    .irWrite(ctrlBus.irWrite),
    .memWrite(ctrlBus.memWrite),
    .regWrite(ctrlBus.regWrite),
    .pcOut(pcOut)
);
